//--- mem_pkg.sv
// ----------------------------------------------------------------------
// Shared widths, AXI codes and FSM encodings for the memory subsystem
// Every AXI transfer is one beat of 8 bytes, no bursts, no error codes
// The memory aliases above address bit MEM_AW + 2
// ----------------------------------------------------------------------
package mem_pkg;

    // Bus widths
    localparam int ADDR_WD  = 32;
    localparam int DATA_WD  = 64;
    localparam int WEN_WD   = 8;
    localparam int ID_WD    = 4;
    localparam int LEN_WD   = 8;
    localparam int SIZE_WD  = 3;
    localparam int BURST_WD = 2;
    localparam int RESP_WD  = 2;

    // AXI IDs and codes
    localparam logic [ID_WD-1:0]    ID_FETCH       = ID_WD'(0);
    localparam logic [ID_WD-1:0]    ID_DATA        = ID_WD'(1);
    localparam logic [SIZE_WD-1:0]  AXI_SIZE_8B    = 3'd3;
    localparam logic [BURST_WD-1:0] AXI_BURST_INCR = 2'd1;
    localparam logic [RESP_WD-1:0]  AXI_RESP_OKAY  = 2'd0;

    // Memory model
    localparam int MEM_AW       = 10;
    localparam int MEM_DEPTH    = 1 << MEM_AW;
    localparam int BYTE_OFF     = $clog2(WEN_WD);
    localparam int READ_LATENCY = 2;
    localparam int LAT_WD       = $clog2(READ_LATENCY + 1);

    // ------------------------------------------------------------------
    // Arbiter FSM encodings
    // ------------------------------------------------------------------
    localparam int FSM_WD = 3;

    localparam logic [FSM_WD-1:0] AR_IDLE    = 3'd0;
    localparam logic [FSM_WD-1:0] AR_REQ     = 3'd1;
    localparam logic [FSM_WD-1:0] AR_OK      = 3'd2;

    localparam logic [FSM_WD-1:0] R_IDLE     = 3'd0;
    localparam logic [FSM_WD-1:0] R_WAIT     = 3'd1;
    localparam logic [FSM_WD-1:0] R_GET      = 3'd2;

    localparam logic [FSM_WD-1:0] AW_IDLE    = 3'd0;
    localparam logic [FSM_WD-1:0] AW_WAIT    = 3'd1;
    localparam logic [FSM_WD-1:0] AW_WAIT_W  = 3'd2;
    localparam logic [FSM_WD-1:0] AW_WAIT_AW = 3'd3;
    localparam logic [FSM_WD-1:0] AW_OK      = 3'd4;

    localparam logic [FSM_WD-1:0] B_IDLE     = 3'd0;
    localparam logic [FSM_WD-1:0] B_WAIT     = 3'd1;
    localparam logic [FSM_WD-1:0] B_GET      = 3'd2;

endpackage

//--- sram_if.sv
`timescale 1ns/1ps
// ----------------------------------------------------------------------
// SRAM-style requester port, level request with one-cycle ready pulse
// Reads answer with a one-cycle valid pulse, stores only with ready
// ----------------------------------------------------------------------
interface sram_if import mem_pkg::*; ();

    logic               en;
    logic               ready;
    logic [WEN_WD-1:0]  wen;
    logic [ADDR_WD-1:0] addr;
    logic [DATA_WD-1:0] wdata;
    logic [DATA_WD-1:0] rdata;
    logic               valid;

    modport requester (
        output en,
        output wen,
        output addr,
        output wdata,
        input  ready,
        input  rdata,
        input  valid
    );

    modport arbiter (
        input  en,
        input  wen,
        input  addr,
        input  wdata,
        output ready,
        output rdata,
        output valid
    );

endinterface

//--- axi_if.sv
`timescale 1ns/1ps
// ----------------------------------------------------------------------
// AXI4 bus limited to single-beat transfers
// No clock inside, both ends share the system clock
// ----------------------------------------------------------------------
interface axi_if import mem_pkg::*; ();

    // Read address and data
    logic [ID_WD-1:0]    arid;
    logic [ADDR_WD-1:0]  araddr;
    logic [LEN_WD-1:0]   arlen;
    logic [SIZE_WD-1:0]  arsize;
    logic [BURST_WD-1:0] arburst;
    logic                arvalid;
    logic                arready;
    logic [ID_WD-1:0]    rid;
    logic [DATA_WD-1:0]  rdata;
    logic [RESP_WD-1:0]  rresp;
    logic                rlast;
    logic                rvalid;
    logic                rready;

    // Write address, data and response
    logic [ID_WD-1:0]    awid;
    logic [ADDR_WD-1:0]  awaddr;
    logic [LEN_WD-1:0]   awlen;
    logic [SIZE_WD-1:0]  awsize;
    logic [BURST_WD-1:0] awburst;
    logic                awvalid;
    logic                awready;
    logic [DATA_WD-1:0]  wdata;
    logic [WEN_WD-1:0]   wstrb;
    logic                wlast;
    logic                wvalid;
    logic                wready;
    logic [ID_WD-1:0]    bid;
    logic [RESP_WD-1:0]  bresp;
    logic                bvalid;
    logic                bready;

    modport master (
        output arid, araddr, arlen, arsize, arburst, arvalid, rready,
        output awid, awaddr, awlen, awsize, awburst, awvalid,
        output wdata, wstrb, wlast, wvalid, bready,
        input  arready, rid, rdata, rresp, rlast, rvalid,
        input  awready, wready, bid, bresp, bvalid
    );

    modport slave (
        input  arid, araddr, arlen, arsize, arburst, arvalid, rready,
        input  awid, awaddr, awlen, awsize, awburst, awvalid,
        input  wdata, wstrb, wlast, wvalid, bready,
        output arready, rid, rdata, rresp, rlast, rvalid,
        output awready, wready, bid, bresp, bvalid
    );

endinterface

//--- axi_arbiter.sv
`timescale 1ns/1ps
// ----------------------------------------------------------------------
// Joins the fetch and data ports onto one single-beat AXI master
// Loads win over fetches, only one read is in flight at a time
// The next store waits for the B response of the previous one
// RRESP, RLAST, BID and BRESP are not looked at
// ----------------------------------------------------------------------
module axi_arbiter import mem_pkg::*; (
    input logic     clk,
    input logic     reset,
    sram_if.arbiter fetch,
    sram_if.arbiter data,
    axi_if.master   axi
);

    logic [FSM_WD-1:0] ar_state;
    logic [FSM_WD-1:0] ar_next;
    logic [FSM_WD-1:0] r_state;
    logic [FSM_WD-1:0] r_next;
    logic [FSM_WD-1:0] aw_state;
    logic [FSM_WD-1:0] aw_next;
    logic [FSM_WD-1:0] b_state;
    logic [FSM_WD-1:0] b_next;
    logic [ID_WD-1:0]  r_id;

    logic load_req;
    logic store_req;
    logic r_free;
    logic b_free;
    logic ar_start;
    logic aw_start;
    logic ar_fire;
    logic r_fire;

    assign load_req  = data.en && (data.wen == '0);
    assign store_req = data.en && (data.wen != '0);
    // A read may start again once its R beat has been taken
    assign r_free    = (r_state != R_WAIT);
    assign b_free    = (b_state != B_WAIT);
    assign ar_start  = (ar_state == AR_IDLE) && r_free && (load_req || fetch.en);
    assign aw_start  = (aw_state == AW_IDLE) && b_free && store_req;
    assign ar_fire   = axi.arvalid && axi.arready;
    assign r_fire    = axi.rvalid && axi.rready;

    // Fixed single-beat attributes
    assign axi.arlen   = '0;
    assign axi.arsize  = AXI_SIZE_8B;
    assign axi.arburst = AXI_BURST_INCR;
    assign axi.awid    = ID_DATA;
    assign axi.awlen   = '0;
    assign axi.awsize  = AXI_SIZE_8B;
    assign axi.awburst = AXI_BURST_INCR;
    assign axi.wlast   = 1'b1;

    // ------------------------------------------------------------------
    // Next-state logic
    // ------------------------------------------------------------------
    always_comb begin
        ar_next = ar_state;
        case (ar_state)
            AR_IDLE: if (ar_start) ar_next = AR_REQ;
            AR_REQ:  if (axi.arready) ar_next = AR_OK;
            AR_OK:   ar_next = AR_IDLE;
            default: ar_next = AR_IDLE;
        endcase
    end

    always_comb begin
        r_next = r_state;
        case (r_state)
            R_IDLE:  if (ar_fire) r_next = R_WAIT;
            R_WAIT:  if (axi.rvalid) r_next = R_GET;
            R_GET:   r_next = R_IDLE;
            default: r_next = R_IDLE;
        endcase
    end

    // AW and W complete independently, in either order
    always_comb begin
        aw_next = aw_state;
        case (aw_state)
            AW_IDLE: if (aw_start) aw_next = AW_WAIT;
            AW_WAIT: begin
                if (axi.awready && axi.wready) begin
                    aw_next = AW_OK;
                end else if (axi.awready) begin
                    aw_next = AW_WAIT_W;
                end else if (axi.wready) begin
                    aw_next = AW_WAIT_AW;
                end
            end
            AW_WAIT_AW: if (axi.awready) aw_next = AW_OK;
            AW_WAIT_W:  if (axi.wready) aw_next = AW_OK;
            AW_OK:      aw_next = AW_IDLE;
            default:    aw_next = AW_IDLE;
        endcase
    end

    always_comb begin
        b_next = b_state;
        case (b_state)
            B_IDLE:  if (aw_state == AW_OK) b_next = B_WAIT;
            B_WAIT:  if (axi.bvalid) b_next = B_GET;
            B_GET:   b_next = B_IDLE;
            default: b_next = B_IDLE;
        endcase
    end

    // ------------------------------------------------------------------
    // State and handshake registers
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            ar_state    <= AR_IDLE;
            r_state     <= R_IDLE;
            aw_state    <= AW_IDLE;
            b_state     <= B_IDLE;
            fetch.ready <= 1'b0;
            fetch.valid <= 1'b0;
            data.ready  <= 1'b0;
            data.valid  <= 1'b0;
            axi.arvalid <= 1'b0;
            axi.rready  <= 1'b0;
            axi.awvalid <= 1'b0;
            axi.wvalid  <= 1'b0;
            axi.bready  <= 1'b0;
        end else begin
            ar_state    <= ar_next;
            r_state     <= r_next;
            aw_state    <= aw_next;
            b_state     <= b_next;
            fetch.ready <= ar_fire && (axi.arid == ID_FETCH);
            data.ready  <= (ar_fire && (axi.arid == ID_DATA)) || (aw_next == AW_OK);
            // Read data steered by ID
            fetch.valid <= r_fire && (axi.rid == ID_FETCH);
            data.valid  <= r_fire && (axi.rid == ID_DATA);
            axi.arvalid <= (ar_next == AR_REQ);
            axi.rready  <= (r_next == R_WAIT);
            axi.awvalid <= (aw_next == AW_WAIT) || (aw_next == AW_WAIT_AW);
            axi.wvalid  <= (aw_next == AW_WAIT) || (aw_next == AW_WAIT_W);
            axi.bready  <= (b_next == B_WAIT);
        end
    end

    always_ff @(posedge clk) begin
        if (ar_start) begin
            axi.arid   <= load_req ? ID_DATA : ID_FETCH;
            axi.araddr <= load_req ? data.addr : fetch.addr;
        end
        if (ar_fire) begin
            r_id <= axi.arid;
        end
        if (r_fire && (axi.rid == ID_FETCH)) begin
            fetch.rdata <= axi.rdata;
        end
        if (r_fire && (axi.rid == ID_DATA)) begin
            data.rdata <= axi.rdata;
        end
        if (aw_start) begin
            axi.awaddr <= data.addr;
            axi.wdata  <= data.wdata;
            axi.wstrb  <= data.wen;
        end
    end

    // ------------------------------------------------------------------
    // Checks against the slave
    // ------------------------------------------------------------------
    a_no_stray_r: assert property (@(posedge clk) disable iff (reset)
        axi.rvalid |-> (r_state == R_WAIT))
        else $error("R beat with no read outstanding");

    a_no_stray_b: assert property (@(posedge clk) disable iff (reset)
        axi.bvalid |-> (b_state == B_WAIT))
        else $error("B beat with no store outstanding");

    a_rid_match: assert property (@(posedge clk) disable iff (reset)
        r_fire |-> (axi.rid == r_id))
        else $error("rid does not match the outstanding read");

    a_one_read: assert property (@(posedge clk) disable iff (reset)
        ar_fire |-> (r_state != R_WAIT))
        else $error("AR issued while a read is outstanding");

endmodule

//--- axi_mem_slave.sv
`timescale 1ns/1ps
// ----------------------------------------------------------------------
// Single-beat AXI memory of MEM_DEPTH doublewords, zero at start
// One read at a time, data returned READ_LATENCY cycles after AR
// One write slot, freed when the B response is taken
// ----------------------------------------------------------------------
module axi_mem_slave import mem_pkg::*; (
    input logic  clk,
    input logic  reset,
    axi_if.slave axi
);

    logic [DATA_WD-1:0] mem [MEM_DEPTH] = '{default: '0};

    logic               rd_pend;
    logic [LAT_WD-1:0]  lat_cnt;
    logic [MEM_AW-1:0]  rd_idx;
    logic               aw_held;
    logic               w_held;
    logic [MEM_AW-1:0]  wr_idx;
    logic [DATA_WD-1:0] wr_data;
    logic [WEN_WD-1:0]  wr_strb;

    logic ar_fire;
    logic aw_fire;
    logic w_fire;
    logic rd_due;
    logic wr_go;

    assign ar_fire = axi.arvalid && axi.arready;
    assign aw_fire = axi.awvalid && axi.awready;
    assign w_fire  = axi.wvalid && axi.wready;
    assign rd_due  = rd_pend && !axi.rvalid && (lat_cnt == '0);
    assign wr_go   = aw_held && w_held;

    assign axi.arready = !rd_pend;
    assign axi.awready = !aw_held && !axi.bvalid;
    assign axi.wready  = !w_held && !axi.bvalid;
    assign axi.rresp   = AXI_RESP_OKAY;
    assign axi.rlast   = 1'b1;
    assign axi.bresp   = AXI_RESP_OKAY;

    // ------------------------------------------------------------------
    // Read channel
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_pend    <= 1'b0;
            lat_cnt    <= '0;
            axi.rvalid <= 1'b0;
        end else if (ar_fire) begin
            rd_pend <= 1'b1;
            lat_cnt <= LAT_WD'(READ_LATENCY - 1);
        end else if (rd_due) begin
            axi.rvalid <= 1'b1;
        end else if (rd_pend && !axi.rvalid) begin
            lat_cnt <= lat_cnt - 1'b1;
        end else if (axi.rvalid && axi.rready) begin
            axi.rvalid <= 1'b0;
            rd_pend    <= 1'b0;
        end
    end

    // rdata stays put while rready is low
    always_ff @(posedge clk) begin
        if (ar_fire) begin
            rd_idx  <= axi.araddr[BYTE_OFF +: MEM_AW];
            axi.rid <= axi.arid;
        end
        if (rd_due) begin
            axi.rdata <= mem[rd_idx];
        end
    end

    // ------------------------------------------------------------------
    // Write channels
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            aw_held    <= 1'b0;
            w_held     <= 1'b0;
            axi.bvalid <= 1'b0;
        end else if (wr_go) begin
            aw_held    <= 1'b0;
            w_held     <= 1'b0;
            axi.bvalid <= 1'b1;
        end else begin
            if (aw_fire) begin
                aw_held <= 1'b1;
            end
            if (w_fire) begin
                w_held <= 1'b1;
            end
            if (axi.bvalid && axi.bready) begin
                axi.bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (aw_fire) begin
            wr_idx  <= axi.awaddr[BYTE_OFF +: MEM_AW];
            axi.bid <= axi.awid;
        end
        if (w_fire) begin
            wr_data <= axi.wdata;
            wr_strb <= axi.wstrb;
        end
    end

    // Byte merge under the strobes
    always_ff @(posedge clk) begin
        if (wr_go) begin
            for (int b = 0; b < WEN_WD; b++) begin
                if (wr_strb[b]) begin
                    mem[wr_idx][8*b +: 8] <= wr_data[8*b +: 8];
                end
            end
        end
    end

    a_ar_single: assert property (@(posedge clk) disable iff (reset)
        ar_fire |-> (axi.arlen == '0) && (axi.arsize == AXI_SIZE_8B)
                    && (axi.arburst == AXI_BURST_INCR))
        else $error("AR is not a single 8-byte beat");

    a_aw_single: assert property (@(posedge clk) disable iff (reset)
        aw_fire |-> (axi.awlen == '0) && (axi.awsize == AXI_SIZE_8B)
                    && (axi.awburst == AXI_BURST_INCR))
        else $error("AW is not a single 8-byte beat");

endmodule

//--- mem_subsystem_top.sv
`timescale 1ns/1ps
// ----------------------------------------------------------------------
// Memory subsystem with a fetch port and a load/store port
// Fetch port is read-only, a nonzero data_wen marks a store
// ----------------------------------------------------------------------
module mem_subsystem_top import mem_pkg::*; (
    input  logic               clk,
    input  logic               reset,
    input  logic               inst_en,
    output logic               inst_ready,
    input  logic [ADDR_WD-1:0] inst_addr,
    output logic [DATA_WD-1:0] inst_rdata,
    output logic               inst_valid,
    input  logic               data_en,
    output logic               data_ready,
    input  logic [WEN_WD-1:0]  data_wen,
    input  logic [ADDR_WD-1:0] data_addr,
    input  logic [DATA_WD-1:0] data_wdata,
    output logic [DATA_WD-1:0] data_rdata,
    output logic               data_valid
);

    sram_if i_fetch_if ();
    sram_if i_data_if ();
    axi_if  i_axi_if ();

    // Fetch side
    assign i_fetch_if.en    = inst_en;
    assign i_fetch_if.wen   = '0;
    assign i_fetch_if.addr  = inst_addr;
    assign i_fetch_if.wdata = '0;
    assign inst_ready       = i_fetch_if.ready;
    assign inst_rdata       = i_fetch_if.rdata;
    assign inst_valid       = i_fetch_if.valid;

    // Load/store side
    assign i_data_if.en    = data_en;
    assign i_data_if.wen   = data_wen;
    assign i_data_if.addr  = data_addr;
    assign i_data_if.wdata = data_wdata;
    assign data_ready      = i_data_if.ready;
    assign data_rdata      = i_data_if.rdata;
    assign data_valid      = i_data_if.valid;

    axi_arbiter i_axi_arbiter (
        .clk   (clk),
        .reset (reset),
        .fetch (i_fetch_if),
        .data  (i_data_if),
        .axi   (i_axi_if)
    );

    axi_mem_slave i_axi_mem_slave (
        .clk   (clk),
        .reset (reset),
        .axi   (i_axi_if)
    );

endmodule

//--- tb_mem_subsystem.sv
`timescale 1ns/1ps
// ----------------------------------------------------------------------
// Testbench for the memory subsystem with one request per port at a time
// Addresses stay in a 16-doubleword window so loads hit earlier stores
// Stores enter the reference memory when data_ready is seen
// ----------------------------------------------------------------------
module tb_mem_subsystem import mem_pkg::*; ();

    localparam int CLK_PERIOD      = 40;
    localparam int RESET_CYCLES    = 16;
    localparam int IDLE_CYCLES     = 20;
    localparam int N_STORE_LOAD    = 4;
    localparam int N_PARTIAL       = 4;
    localparam int N_FETCH         = 6;
    localparam int N_PAIR          = 3;
    localparam int N_RANDOM        = 60;
    localparam int NUM_TXNS        = 2 * N_STORE_LOAD + 2 * N_PARTIAL + N_FETCH
                                     + 2 * N_PAIR + N_RANDOM;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + IDLE_CYCLES + 200 * NUM_TXNS;
    localparam int WINDOW_BITS     = 4;
    localparam logic [ADDR_WD-1:0] WINDOW_BASE = 32'h0000_0100;
    localparam logic [31:0]        LFSR_TAPS   = 32'hA300_0000;

    logic               clk = 1'b0;
    logic               reset;
    logic               inst_en;
    logic               inst_ready;
    logic [ADDR_WD-1:0] inst_addr;
    logic [DATA_WD-1:0] inst_rdata;
    logic               inst_valid;
    logic               data_en;
    logic               data_ready;
    logic [WEN_WD-1:0]  data_wen;
    logic [ADDR_WD-1:0] data_addr;
    logic [DATA_WD-1:0] data_wdata;
    logic [DATA_WD-1:0] data_rdata;
    logic               data_valid;

    logic [31:0]        lfsr;
    logic [DATA_WD-1:0] ref_mem [MEM_DEPTH];
    string              test_name;
    logic               inst_busy;
    logic               data_busy;
    int                 cycle_count = 0;
    int                 inst_ready_cycle;
    int                 data_ready_cycle;

    mem_subsystem_top i_mem_subsystem_top (
        .clk        (clk),
        .reset      (reset),
        .inst_en    (inst_en),
        .inst_ready (inst_ready),
        .inst_addr  (inst_addr),
        .inst_rdata (inst_rdata),
        .inst_valid (inst_valid),
        .data_en    (data_en),
        .data_ready (data_ready),
        .data_wen   (data_wen),
        .data_addr  (data_addr),
        .data_wdata (data_wdata),
        .data_rdata (data_rdata),
        .data_valid (data_valid)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) cycle_count <= cycle_count + 1;

    // ------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------
    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check_word(input string port, input logic [DATA_WD-1:0] expected,
                              input logic [DATA_WD-1:0] actual);
        assert (actual === expected) else
            fail_run($sformatf("Mismatch in %s (%s): expected %h, actual %h",
                               test_name, port, expected, actual));
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ LFSR_TAPS;
        end
        return state >> 1;
    endfunction

    // One LFSR step per bit taken
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value[i] = lfsr[0];
            lfsr     = lfsr_next(lfsr);
        end
        return value;
    endfunction

    function automatic logic [ADDR_WD-1:0] window_addr();
        logic [WINDOW_BITS-1:0] slot;
        slot = WINDOW_BITS'(rand_bits(WINDOW_BITS));
        return WINDOW_BASE + (ADDR_WD'(slot) << BYTE_OFF);
    endfunction

    function automatic logic [MEM_AW-1:0] mem_index(input logic [ADDR_WD-1:0] addr);
        return addr[BYTE_OFF +: MEM_AW];
    endfunction

    function automatic logic [DATA_WD-1:0] merge_bytes(input logic [DATA_WD-1:0] old_word,
                                                       input logic [DATA_WD-1:0] new_word,
                                                       input logic [WEN_WD-1:0]  strb);
        logic [DATA_WD-1:0] merged;
        merged = old_word;
        for (int b = 0; b < WEN_WD; b++) begin
            if (strb[b]) merged[8*b +: 8] = new_word[8*b +: 8];
        end
        return merged;
    endfunction

    // ------------------------------------------------------------------
    // Port tasks
    // ------------------------------------------------------------------
    task automatic fetch_word(input logic [ADDR_WD-1:0] addr);
        logic [DATA_WD-1:0] expected;
        expected = ref_mem[mem_index(addr)];
        @(posedge clk);
        inst_en   <= 1'b1;
        inst_addr <= addr;
        inst_busy <= 1'b1;
        do begin
            @(posedge clk);
            assert (!inst_valid) else fail_run("inst_valid came before inst_ready");
        end while (!inst_ready);
        inst_ready_cycle = cycle_count;
        inst_en <= 1'b0;
        do @(posedge clk); while (!inst_valid);
        inst_busy <= 1'b0;
        check_word("fetch", expected, inst_rdata);
    endtask

    task automatic load_word(input logic [ADDR_WD-1:0] addr, output logic [DATA_WD-1:0] got);
        logic [DATA_WD-1:0] expected;
        expected = ref_mem[mem_index(addr)];
        @(posedge clk);
        data_en   <= 1'b1;
        data_wen  <= '0;
        data_addr <= addr;
        data_busy <= 1'b1;
        do begin
            @(posedge clk);
            assert (!data_valid) else fail_run("data_valid came before data_ready");
        end while (!data_ready);
        data_ready_cycle = cycle_count;
        data_en <= 1'b0;
        do @(posedge clk); while (!data_valid);
        data_busy <= 1'b0;
        got = data_rdata;
        check_word("load", expected, got);
    endtask

    task automatic store_word(input logic [ADDR_WD-1:0] addr, input logic [DATA_WD-1:0] wdata,
                              input logic [WEN_WD-1:0] strb);
        logic [MEM_AW-1:0] idx;
        idx = mem_index(addr);
        @(posedge clk);
        data_en    <= 1'b1;
        data_wen   <= strb;
        data_addr  <= addr;
        data_wdata <= wdata;
        data_busy  <= 1'b1;
        do begin
            @(posedge clk);
            assert (!data_valid) else fail_run("data_valid seen during a store");
        end while (!data_ready);
        data_en   <= 1'b0;
        data_wen  <= '0;
        data_busy <= 1'b0;
        ref_mem[idx] = merge_bytes(ref_mem[idx], wdata, strb);
    endtask

    task automatic fetch_and_load(input logic [ADDR_WD-1:0] fetch_addr,
                                  input logic [ADDR_WD-1:0] load_addr);
        logic [DATA_WD-1:0] got;
        fork
            fetch_word(fetch_addr);
            load_word(load_addr, got);
        join
        assert (data_ready_cycle < inst_ready_cycle) else
            fail_run("inst_ready came before data_ready on a same-cycle fetch and load");
    endtask

    // ------------------------------------------------------------------
    // Response checks
    // ------------------------------------------------------------------
    a_inst_quiet: assert property (@(posedge clk) disable iff (reset)
        !inst_busy |-> (!inst_ready && !inst_valid))
        else fail_run("fetch port responded with no fetch pending");

    a_data_quiet: assert property (@(posedge clk) disable iff (reset)
        !data_busy |-> (!data_ready && !data_valid))
        else fail_run("data port responded with no request pending");

    a_inst_ready_pulse: assert property (@(posedge clk) disable iff (reset)
        inst_ready |=> !inst_ready) else fail_run("inst_ready high for two cycles");

    a_inst_valid_pulse: assert property (@(posedge clk) disable iff (reset)
        inst_valid |=> !inst_valid) else fail_run("inst_valid high for two cycles");

    a_data_ready_pulse: assert property (@(posedge clk) disable iff (reset)
        data_ready |=> !data_ready) else fail_run("data_ready high for two cycles");

    a_data_valid_pulse: assert property (@(posedge clk) disable iff (reset)
        data_valid |=> !data_valid) else fail_run("data_valid high for two cycles");

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        fail_run($sformatf("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES));
    end

    // ------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------
    initial begin
        logic [ADDR_WD-1:0] addr;
        logic [DATA_WD-1:0] wdata;
        logic [DATA_WD-1:0] expected;
        logic [DATA_WD-1:0] got;
        logic [WEN_WD-1:0]  strb;
        logic [1:0]         op;

        reset      = 1'b1;
        inst_en    = 1'b0;
        inst_addr  = '0;
        data_en    = 1'b0;
        data_wen   = '0;
        data_addr  = '0;
        data_wdata = '0;
        inst_busy  = 1'b0;
        data_busy  = 1'b0;
        lfsr       = 32'd29;
        test_name  = "reset";
        for (int i = 0; i < MEM_DEPTH; i++) ref_mem[i] = '0;

        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;

        test_name = "idle after reset";
        repeat (IDLE_CYCLES) @(posedge clk);

        test_name = "store then load";
        for (int i = 0; i < N_STORE_LOAD; i++) begin
            addr  = window_addr();
            wdata = rand_bits(DATA_WD);
            store_word(addr, wdata, '1);
            load_word(addr, got);
            check_word("stored word", wdata, got);
        end

        test_name = "partial store merge";
        for (int i = 0; i < N_PARTIAL; i++) begin
            addr  = window_addr();
            wdata = rand_bits(DATA_WD);
            strb  = WEN_WD'(rand_bits(WEN_WD));
            if (strb == '0 || strb == '1) strb = 8'h3c;
            expected = merge_bytes(ref_mem[mem_index(addr)], wdata, strb);
            store_word(addr, wdata, strb);
            load_word(addr, got);
            check_word("merged word", expected, got);
        end

        test_name = "fetch";
        for (int i = 0; i < N_FETCH; i++) fetch_word(window_addr());

        test_name = "fetch and load together";
        for (int i = 0; i < N_PAIR; i++) begin
            addr = window_addr();
            fetch_and_load(addr, window_addr());
        end

        test_name = "random mix";
        for (int i = 0; i < N_RANDOM; i++) begin
            op   = 2'(rand_bits(2));
            addr = window_addr();
            case (op)
                2'd0: fetch_word(addr);
                2'd1: load_word(addr, got);
                default: begin
                    wdata = rand_bits(DATA_WD);
                    strb  = WEN_WD'(rand_bits(WEN_WD));
                    if (strb == '0) strb = 8'h01;
                    store_word(addr, wdata, strb);
                end
            endcase
        end

        repeat (4) @(posedge clk);
        $display("Test OK");
        $finish;
    end

endmodule

//--- sim.f
mem_pkg.sv
sram_if.sv
axi_if.sv
axi_arbiter.sv
axi_mem_slave.sv
mem_subsystem_top.sv
tb_mem_subsystem.sv

//--- Makefile
# Verilator lint and simulation of the memory subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_mem_subsystem
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Test OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
